/* rtl/wasm_pkg.sv */
// ----------------------------------------------------------------------
// Shared widths, opcode bytes and immediate formats for the wasm decoder.
// Referenced by scoped name from every decoder module.
// ----------------------------------------------------------------------
package wasm_pkg;

    // datapath widths
    localparam int BYTE_W        = 8;
    localparam int IMM_W         = 64;
    localparam int PC_W          = 32;
    localparam int LEN_W         = 8;
    localparam int LEB_LEN_W     = 4;
    localparam int LEB_MAX_BYTES = 10;

    // structured control
    localparam logic [7:0] OPC_BLOCK          = 8'h02;
    localparam logic [7:0] OPC_LOOP           = 8'h03;
    localparam logic [7:0] OPC_IF             = 8'h04;
    localparam logic [7:0] OPC_BR             = 8'h0C;
    localparam logic [7:0] OPC_BR_IF          = 8'h0D;
    localparam logic [7:0] OPC_CALL           = 8'h10;
    localparam logic [7:0] OPC_CALL_INDIRECT  = 8'h11;

    // variable and table access
    localparam logic [7:0] OPC_LOCAL_GET      = 8'h20;
    localparam logic [7:0] OPC_LOCAL_SET      = 8'h21;
    localparam logic [7:0] OPC_LOCAL_TEE      = 8'h22;
    localparam logic [7:0] OPC_GLOBAL_GET     = 8'h23;
    localparam logic [7:0] OPC_GLOBAL_SET     = 8'h24;
    localparam logic [7:0] OPC_TABLE_GET      = 8'h25;
    localparam logic [7:0] OPC_TABLE_SET      = 8'h26;

    // loads and stores span one contiguous range, all with align + offset
    localparam logic [7:0] OPC_MEM_FIRST      = 8'h28;
    localparam logic [7:0] OPC_MEM_LAST       = 8'h3E;
    localparam logic [7:0] OPC_MEMORY_SIZE    = 8'h3F;
    localparam logic [7:0] OPC_MEMORY_GROW    = 8'h40;

    // constants
    localparam logic [7:0] OPC_I32_CONST      = 8'h41;
    localparam logic [7:0] OPC_I64_CONST      = 8'h42;
    localparam logic [7:0] OPC_F32_CONST      = 8'h43;
    localparam logic [7:0] OPC_F64_CONST      = 8'h44;

    // reference instructions that carry an index
    localparam logic [7:0] OPC_REF_FUNC       = 8'hD2;
    localparam logic [7:0] OPC_BR_ON_NULL     = 8'hD5;
    localparam logic [7:0] OPC_BR_ON_NON_NULL = 8'hD6;

    // block type bytes, anything else is read as a type index
    localparam logic [7:0] BT_EMPTY           = 8'h40;
    localparam logic [7:0] BT_VALTYPE_LO      = 8'h7C;
    localparam logic [7:0] BT_VALTYPE_HI      = 8'h7F;
    localparam logic [7:0] BT_FUNCREF         = 8'h70;
    localparam logic [7:0] BT_EXTERNREF       = 8'h6F;

    // what follows the opcode byte
    typedef enum logic [3:0] {
        FMT_NONE,
        FMT_BLOCKTYPE,
        FMT_ULEB,
        FMT_ULEB_PAIR,
        FMT_RAW_BYTE,
        FMT_SLEB32,
        FMT_SLEB64,
        FMT_RAW32,
        FMT_RAW64
    } imm_fmt_t;

endpackage

/* rtl/wasm_leb_decoder.sv */
// ----------------------------------------------------------------------
// Combinational LEB128 field decoder, unsigned or signed by parameter.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module wasm_leb_decoder #(
    // sign-extension point in bits, 0 selects unsigned decode
    parameter int SIGNED_WIDTH = 0
) (
    input  logic [wasm_pkg::LEB_MAX_BYTES*wasm_pkg::BYTE_W-1:0] bytes,
    output logic [wasm_pkg::IMM_W-1:0]                          value,
    output logic [wasm_pkg::LEB_LEN_W-1:0]                      length
);

    typedef logic [wasm_pkg::IMM_W-1:0]     imm_t;
    typedef logic [wasm_pkg::LEB_LEN_W-1:0] leb_len_t;

    always_comb begin
        logic [wasm_pkg::BYTE_W-1:0] cur;
        logic                        done;

        value  = '0;
        length = '0;
        done   = 1'b0;
        cur    = '0;

        for (int i = 0; i < wasm_pkg::LEB_MAX_BYTES; i++) begin
            if (!done) begin
                cur    = bytes[i*wasm_pkg::BYTE_W +: wasm_pkg::BYTE_W];
                // 7 payload bits per byte, least significant group first
                value  = value | (imm_t'(cur[6:0]) << (7 * i));
                length = leb_len_t'(i + 1);

                if (!cur[7]) begin
                    done = 1'b1;
                    // bit 6 of the final group carries the sign
                    if ((SIGNED_WIDTH > 0) && ((7 * (i + 1)) < SIGNED_WIDTH) && cur[6]) begin
                        value = value | ({wasm_pkg::IMM_W{1'b1}} << (7 * (i + 1)));
                    end
                end
            end
        end
        // an unterminated field stops at LEB_MAX_BYTES with no extension
    end

endmodule

/* rtl/wasm_opcode_classifier.sv */
// ----------------------------------------------------------------------
// Maps the first instruction byte to the immediate format that follows.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module wasm_opcode_classifier (
    input  logic [wasm_pkg::BYTE_W-1:0] opcode,
    output wasm_pkg::imm_fmt_t          fmt
);

    always_comb begin
        case (opcode) inside
            // block, loop and if take a block type
            wasm_pkg::OPC_BLOCK,
            wasm_pkg::OPC_LOOP,
            wasm_pkg::OPC_IF: begin
                fmt = wasm_pkg::FMT_BLOCKTYPE;
            end

            // branch labels and function index
            wasm_pkg::OPC_BR,
            wasm_pkg::OPC_BR_IF,
            wasm_pkg::OPC_CALL: begin
                fmt = wasm_pkg::FMT_ULEB;
            end

            // local and global index
            wasm_pkg::OPC_LOCAL_GET,
            wasm_pkg::OPC_LOCAL_SET,
            wasm_pkg::OPC_LOCAL_TEE,
            wasm_pkg::OPC_GLOBAL_GET,
            wasm_pkg::OPC_GLOBAL_SET: begin
                fmt = wasm_pkg::FMT_ULEB;
            end

            // table index
            wasm_pkg::OPC_TABLE_GET,
            wasm_pkg::OPC_TABLE_SET: begin
                fmt = wasm_pkg::FMT_ULEB;
            end

            // function index or label on the reference ops
            wasm_pkg::OPC_REF_FUNC,
            wasm_pkg::OPC_BR_ON_NULL,
            wasm_pkg::OPC_BR_ON_NON_NULL: begin
                fmt = wasm_pkg::FMT_ULEB;
            end

            // type index + table index
            wasm_pkg::OPC_CALL_INDIRECT: begin
                fmt = wasm_pkg::FMT_ULEB_PAIR;
            end

            // memarg is align then offset
            [wasm_pkg::OPC_MEM_FIRST:wasm_pkg::OPC_MEM_LAST]: begin
                fmt = wasm_pkg::FMT_ULEB_PAIR;
            end

            // memory index is a single raw byte here
            wasm_pkg::OPC_MEMORY_SIZE,
            wasm_pkg::OPC_MEMORY_GROW: begin
                fmt = wasm_pkg::FMT_RAW_BYTE;
            end

            wasm_pkg::OPC_I32_CONST: begin
                fmt = wasm_pkg::FMT_SLEB32;
            end

            wasm_pkg::OPC_I64_CONST: begin
                fmt = wasm_pkg::FMT_SLEB64;
            end

            // IEEE 754 payloads stored little-endian
            wasm_pkg::OPC_F32_CONST: begin
                fmt = wasm_pkg::FMT_RAW32;
            end

            wasm_pkg::OPC_F64_CONST: begin
                fmt = wasm_pkg::FMT_RAW64;
            end

            // numeric, comparison, conversion, else, ref.is_null and unknown bytes
            default: begin
                fmt = wasm_pkg::FMT_NONE;
            end
        endcase
    end

endmodule

/* rtl/wasm_immediate_unit.sv */
// ----------------------------------------------------------------------
// Extracts immediates and the instruction length for a given format.
// Driven by the classifier output and the lookahead window.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module wasm_immediate_unit #(
    parameter int WINDOW_BYTES = 16
) (
    input  wasm_pkg::imm_fmt_t                       fmt,
    input  logic [WINDOW_BYTES*wasm_pkg::BYTE_W-1:0] window,
    output logic [wasm_pkg::IMM_W-1:0]               immediate,
    output logic [wasm_pkg::IMM_W-1:0]               immediate2,
    output logic                                     has_immediate,
    output logic                                     has_immediate2,
    output logic [wasm_pkg::LEN_W-1:0]               instr_length
);

    localparam int LEB_BITS = wasm_pkg::LEB_MAX_BYTES * wasm_pkg::BYTE_W;
    // room for a second field starting as late as byte LEB_MAX_BYTES + 1
    localparam int EXT_BITS = (WINDOW_BYTES + wasm_pkg::LEB_MAX_BYTES) * wasm_pkg::BYTE_W;

    typedef logic [wasm_pkg::IMM_W-1:0] imm_t;
    typedef logic [wasm_pkg::LEN_W-1:0] len_t;

    logic [LEB_BITS-1:0]               leb_first_bytes;
    logic [LEB_BITS-1:0]               leb_second_bytes;
    logic [EXT_BITS-1:0]               window_ext;
    logic [wasm_pkg::BYTE_W-1:0]       arg_byte;
    logic                              arg_is_type;
    logic [wasm_pkg::IMM_W-1:0]        uleb1_value;
    logic [wasm_pkg::IMM_W-1:0]        uleb2_value;
    logic [wasm_pkg::IMM_W-1:0]        sleb32_value;
    logic [wasm_pkg::IMM_W-1:0]        sleb64_value;
    logic [wasm_pkg::LEB_LEN_W-1:0]    uleb1_len;
    logic [wasm_pkg::LEB_LEN_W-1:0]    uleb2_len;
    logic [wasm_pkg::LEB_LEN_W-1:0]    sleb32_len;
    logic [wasm_pkg::LEB_LEN_W-1:0]    sleb64_len;

    // first field always starts right after the opcode
    assign leb_first_bytes  = window[wasm_pkg::BYTE_W +: LEB_BITS];
    assign window_ext       = EXT_BITS'(window);
    assign leb_second_bytes = LEB_BITS'(window_ext >> ((int'(uleb1_len) + 1) * wasm_pkg::BYTE_W));

    assign arg_byte    = window[wasm_pkg::BYTE_W +: wasm_pkg::BYTE_W];
    assign arg_is_type = arg_byte inside {wasm_pkg::BT_EMPTY, wasm_pkg::BT_FUNCREF,
                                          wasm_pkg::BT_EXTERNREF,
                                          [wasm_pkg::BT_VALTYPE_LO:wasm_pkg::BT_VALTYPE_HI]};

    wasm_leb_decoder #(.SIGNED_WIDTH(0)) u_uleb_first (
        .bytes  (leb_first_bytes),
        .value  (uleb1_value),
        .length (uleb1_len)
    );

    wasm_leb_decoder #(.SIGNED_WIDTH(0)) u_uleb_second (
        .bytes  (leb_second_bytes),
        .value  (uleb2_value),
        .length (uleb2_len)
    );

    wasm_leb_decoder #(.SIGNED_WIDTH(32)) u_sleb32 (
        .bytes  (leb_first_bytes),
        .value  (sleb32_value),
        .length (sleb32_len)
    );

    wasm_leb_decoder #(.SIGNED_WIDTH(64)) u_sleb64 (
        .bytes  (leb_first_bytes),
        .value  (sleb64_value),
        .length (sleb64_len)
    );

    always_comb begin
        immediate      = '0;
        immediate2     = '0;
        has_immediate  = 1'b0;
        has_immediate2 = 1'b0;
        instr_length   = len_t'(1);

        case (fmt)
            wasm_pkg::FMT_BLOCKTYPE: begin
                has_immediate = 1'b1;
                if (arg_is_type) begin
                    immediate    = imm_t'(arg_byte);
                    instr_length = len_t'(2);
                end else begin
                    immediate    = uleb1_value;
                    instr_length = len_t'(uleb1_len) + len_t'(1);
                end
            end
            wasm_pkg::FMT_ULEB: begin
                has_immediate = 1'b1;
                immediate     = uleb1_value;
                instr_length  = len_t'(uleb1_len) + len_t'(1);
            end
            wasm_pkg::FMT_ULEB_PAIR: begin
                has_immediate  = 1'b1;
                has_immediate2 = 1'b1;
                immediate      = uleb1_value;
                immediate2     = uleb2_value;
                instr_length   = len_t'(uleb1_len) + len_t'(uleb2_len) + len_t'(1);
            end
            wasm_pkg::FMT_RAW_BYTE: begin
                has_immediate = 1'b1;
                immediate     = imm_t'(arg_byte);
                instr_length  = len_t'(2);
            end
            wasm_pkg::FMT_SLEB32: begin
                has_immediate = 1'b1;
                immediate     = sleb32_value;
                instr_length  = len_t'(sleb32_len) + len_t'(1);
            end
            wasm_pkg::FMT_SLEB64: begin
                has_immediate = 1'b1;
                immediate     = sleb64_value;
                instr_length  = len_t'(sleb64_len) + len_t'(1);
            end
            // window is byte 0 low, so the raw bytes already read little-endian
            wasm_pkg::FMT_RAW32: begin
                has_immediate = 1'b1;
                immediate     = imm_t'(window[wasm_pkg::BYTE_W +: 4*wasm_pkg::BYTE_W]);
                instr_length  = len_t'(5);
            end
            wasm_pkg::FMT_RAW64: begin
                has_immediate = 1'b1;
                immediate     = window[wasm_pkg::BYTE_W +: wasm_pkg::IMM_W];
                instr_length  = len_t'(9);
            end
            default: begin
                // FMT_NONE keeps the single-byte defaults
                instr_length = len_t'(1);
            end
        endcase
    end

endmodule

/* rtl/wasm_decoder.sv */
// ----------------------------------------------------------------------
// Pipelined WebAssembly instruction decoder, one instruction per cycle.
// Results appear one clock after a qualified valid_in strobe.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module wasm_decoder #(
    parameter int WINDOW_BYTES = 16
) (
    input  logic                                     clk,
    input  logic                                     arst_n,

    input  logic                                     valid_in,
    input  logic [wasm_pkg::PC_W-1:0]                pc,
    input  logic [WINDOW_BYTES*wasm_pkg::BYTE_W-1:0] window,
    input  logic [4:0]                               bytes_available,

    output logic                                     valid_out,
    output logic [wasm_pkg::BYTE_W-1:0]              opcode,
    output logic [wasm_pkg::IMM_W-1:0]               immediate,
    output logic [wasm_pkg::IMM_W-1:0]               immediate2,
    output logic                                     has_immediate,
    output logic                                     has_immediate2,
    output logic [wasm_pkg::LEN_W-1:0]               instr_length,
    output logic [wasm_pkg::PC_W-1:0]                next_pc
);

    typedef logic [wasm_pkg::PC_W-1:0] pc_t;

    logic                          accept;
    logic [wasm_pkg::BYTE_W-1:0]   opcode_byte;
    wasm_pkg::imm_fmt_t            fmt;
    logic [wasm_pkg::IMM_W-1:0]    dec_immediate;
    logic [wasm_pkg::IMM_W-1:0]    dec_immediate2;
    logic                          dec_has_immediate;
    logic                          dec_has_immediate2;
    logic [wasm_pkg::LEN_W-1:0]    dec_length;

    // an empty window carries no instruction
    assign accept      = valid_in && (bytes_available != '0);
    assign opcode_byte = window[wasm_pkg::BYTE_W-1:0];

    wasm_opcode_classifier u_classifier (
        .opcode (opcode_byte),
        .fmt    (fmt)
    );

    wasm_immediate_unit #(.WINDOW_BYTES(WINDOW_BYTES)) u_imm (
        .fmt            (fmt),
        .window         (window),
        .immediate      (dec_immediate),
        .immediate2     (dec_immediate2),
        .has_immediate  (dec_has_immediate),
        .has_immediate2 (dec_has_immediate2),
        .instr_length   (dec_length)
    );

    // output stage, data holds while no new instruction is accepted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out      <= 1'b0;
            opcode         <= '0;
            immediate      <= '0;
            immediate2     <= '0;
            has_immediate  <= 1'b0;
            has_immediate2 <= 1'b0;
            instr_length   <= '0;
            next_pc        <= '0;
        end else begin
            valid_out <= accept;
            if (accept) begin
                opcode         <= opcode_byte;
                immediate      <= dec_immediate;
                immediate2     <= dec_immediate2;
                has_immediate  <= dec_has_immediate;
                has_immediate2 <= dec_has_immediate2;
                instr_length   <= dec_length;
                next_pc        <= pc + pc_t'(dec_length);
            end
        end
    end

endmodule

/* tests/tb_wasm_ref.svh */
// ----------------------------------------------------------------------
// LEB encoders and the reference decoder, included in the testbench.
// ----------------------------------------------------------------------
`ifndef TB_WASM_REF_SVH
`define TB_WASM_REF_SVH

    // bytes past the window read as zero
    function automatic logic [7:0] win_byte(input logic [WIN_BITS-1:0] w, input int n);
        if (n >= WINDOW_BYTES) begin
            return 8'h00;
        end
        return w[n*8 +: 8];
    endfunction

    // n byte LEB field at byte pos, longer than needed means padded
    function automatic logic [WIN_BITS-1:0] put_leb(input logic [WIN_BITS-1:0] w,
            input int pos, input logic [63:0] val, input int n);
        logic [WIN_BITS-1:0] r;
        logic signed [63:0]  grp;
        r = w;
        for (int i = 0; i < n; i++) begin
            grp = $signed(val) >>> (7 * i);
            r[(pos + i)*8 +: 8] = {(i != n - 1), grp[6:0]};
        end
        return r;
    endfunction

    // sign_w of 0 reads the field unsigned
    function automatic void read_leb(input logic [WIN_BITS-1:0] w, input int pos,
            input int sign_w, output logic [63:0] val, output int len);
        logic [7:0] b;
        val = 64'd0;
        len = 0;
        b   = 8'h80;
        for (int i = 0; i < wasm_pkg::LEB_MAX_BYTES && b[7]; i++) begin
            b   = win_byte(w, pos + i);
            val = val | (64'(b[6:0]) << (7 * i));
            len = i + 1;
        end
        // sign sits in bit 6 of the closing byte
        if (!b[7] && sign_w > 0 && 7 * len < sign_w && b[6]) begin
            val = val | ({64{1'b1}} << (7 * len));
        end
    endfunction

    function automatic void wasm_ref_decode(input logic [WIN_BITS-1:0] w,
            output logic [63:0] imm, output logic [63:0] imm2,
            output logic has1, output logic has2, output int len);
        logic [7:0] op;
        logic [7:0] arg;
        int         len1;
        int         len2;
        op   = win_byte(w, 0);
        arg  = win_byte(w, 1);
        imm  = 64'd0;
        imm2 = 64'd0;
        has1 = (op >= wasm_pkg::OPC_BLOCK && op <= wasm_pkg::OPC_IF)
            || (op inside {wasm_pkg::OPC_BR, wasm_pkg::OPC_BR_IF, wasm_pkg::OPC_CALL,
                           [wasm_pkg::OPC_LOCAL_GET:wasm_pkg::OPC_TABLE_SET],
                           wasm_pkg::OPC_REF_FUNC, wasm_pkg::OPC_BR_ON_NULL,
                           wasm_pkg::OPC_BR_ON_NON_NULL, wasm_pkg::OPC_CALL_INDIRECT,
                           [wasm_pkg::OPC_MEM_FIRST:wasm_pkg::OPC_F64_CONST]});
        has2 = (op == wasm_pkg::OPC_CALL_INDIRECT)
            || (op >= wasm_pkg::OPC_MEM_FIRST && op <= wasm_pkg::OPC_MEM_LAST);
        len  = 1;
        read_leb(w, 1, 0, imm, len1);
        if (op >= wasm_pkg::OPC_BLOCK && op <= wasm_pkg::OPC_IF) begin
            // value types and reference types are one byte, else a type index
            if (arg == wasm_pkg::BT_EMPTY || arg == wasm_pkg::BT_FUNCREF
                    || arg == wasm_pkg::BT_EXTERNREF
                    || (arg >= wasm_pkg::BT_VALTYPE_LO && arg <= wasm_pkg::BT_VALTYPE_HI)) begin
                imm = 64'(arg);
                len = 2;
            end else begin
                len = 1 + len1;
            end
        end else if (has2) begin
            read_leb(w, 1 + len1, 0, imm2, len2);
            len = 1 + len1 + len2;
        end else if (op == wasm_pkg::OPC_MEMORY_SIZE || op == wasm_pkg::OPC_MEMORY_GROW) begin
            imm = 64'(arg);
            len = 2;
        end else if (op == wasm_pkg::OPC_I32_CONST || op == wasm_pkg::OPC_I64_CONST) begin
            read_leb(w, 1, (op == wasm_pkg::OPC_I32_CONST) ? 32 : 64, imm, len1);
            len = 1 + len1;
        end else if (op == wasm_pkg::OPC_F32_CONST || op == wasm_pkg::OPC_F64_CONST) begin
            imm = 64'd0;
            len = (op == wasm_pkg::OPC_F32_CONST) ? 5 : 9;
            for (int i = 1; i < len; i++) begin
                imm = imm | (64'(win_byte(w, i)) << (8 * (i - 1)));
            end
        end else if (has1) begin
            len = 1 + len1;
        end else begin
            imm = 64'd0;
        end
    endfunction

`endif

/* tests/tb_wasm_decoder.sv */
// ----------------------------------------------------------------------
// Testbench for the wasm decoder, every issued window checked a cycle on.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_wasm_decoder;

    localparam int WINDOW_BYTES = 16;
    localparam int WIN_BITS     = WINDOW_BYTES * 8;
    localparam int TIMEOUT      = 40;

    logic                clk;
    logic                arst_n;
    logic                valid_in;
    logic [31:0]         pc;
    logic [WIN_BITS-1:0] window;
    logic [4:0]          bytes_available;
    logic                valid_out;
    logic [7:0]          opcode;
    logic [63:0]         immediate;
    logic [63:0]         immediate2;
    logic                has_immediate;
    logic                has_immediate2;
    logic [7:0]          instr_length;
    logic [31:0]         next_pc;

    int seed  = 32'h2073;
    int cycle = 0;

    // issued instructions waiting for their result
    logic [WIN_BITS-1:0] win_q [$];
    logic [31:0]         pc_q [$];
    int                  cyc_q [$];

    `include "tb_wasm_ref.svh"

    wasm_decoder #(.WINDOW_BYTES(WINDOW_BYTES)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [WIN_BITS-1:0] noise_window(input logic [7:0] op);
        logic [WIN_BITS-1:0] w;
        for (int i = 0; i < WINDOW_BYTES / 4; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        w[7:0] = op;
        return w;
    endfunction

    function automatic int rand_len(input int max);
        return 1 + int'($unsigned($random(seed)) % max);
    endfunction

    // fits in n LEB groups
    function automatic logic [63:0] rand_uval(input int n);
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        return v & ((64'd1 << (7 * n)) - 64'd1);
    endfunction

    // sign-extended from bit width-1
    function automatic logic [63:0] rand_sval(input int width);
        logic signed [63:0] s;
        s = {$random(seed), $random(seed)};
        s = s <<< (64 - width);
        return s >>> (64 - width);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: time %0t %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic issue(input logic [WIN_BITS-1:0] w, input bit back_to_back);
        @(negedge clk);
        valid_in        = 1'b1;
        pc              = $random(seed);
        window          = w;
        bytes_available = 5'(WINDOW_BYTES);
        win_q.push_back(w);
        pc_q.push_back(pc);
        cyc_q.push_back(cycle);
        if (!back_to_back) begin
            @(negedge clk);
            valid_in = 1'b0;
        end
    endtask

    initial begin : compare
        logic [WIN_BITS-1:0] w;
        logic [31:0]         epc;
        logic [63:0]         e_imm;
        logic [63:0]         e_imm2;
        logic                e_has1;
        logic                e_has2;
        int                  e_len;
        int                  ecyc;
        int                  idle;
        idle = 0;
        forever begin
            @(negedge clk);
            if (valid_out && win_q.size() == 0) begin
                abort_run("valid_out was high with no instruction pending");
            end else if (valid_out) begin
                w    = win_q.pop_front();
                epc  = pc_q.pop_front();
                ecyc = cyc_q.pop_front();
                idle = 0;
                wasm_ref_decode(w, e_imm, e_imm2, e_has1, e_has2, e_len);
                check("output cycle", 64'(cycle), 64'(ecyc + 1));
                check("opcode", 64'(opcode), 64'(w[7:0]));
                check("immediate", immediate, e_imm);
                check("immediate2", immediate2, e_imm2);
                check("has_immediate", 64'(has_immediate), 64'(e_has1));
                check("has_immediate2", 64'(has_immediate2), 64'(e_has2));
                check("instr_length", 64'(instr_length), 64'(e_len));
                check("next_pc", 64'(next_pc), 64'(epc + 32'(e_len)));
            end else if (win_q.size() != 0) begin
                idle = idle + 1;
                if (idle > TIMEOUT) begin
                    abort_run("timed out waiting for valid_out");
                end
            end
        end
    end

    initial begin : stimulus
        logic [WIN_BITS-1:0] w;
        int                  n1;
        int                  n2;
        int                  wait_cnt;
        valid_in        = 1'b0;
        pc              = '0;
        window          = '0;
        bytes_available = '0;
        arst_n          = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        // every output clears in reset
        check("valid_out", 64'(valid_out), 64'd0);
        check("opcode", 64'(opcode), 64'd0);
        check("immediate", immediate, 64'd0);
        check("immediate2", immediate2, 64'd0);
        check("has_immediate", 64'(has_immediate), 64'd0);
        check("has_immediate2", 64'(has_immediate2), 64'd0);
        check("instr_length", 64'(instr_length), 64'd0);
        check("next_pc", 64'(next_pc), 64'd0);
        // strobe with an empty window yields nothing
        valid_in = 1'b1;
        window   = noise_window(wasm_pkg::OPC_CALL);
        repeat (3) @(negedge clk);
        check("valid_out", 64'(valid_out), 64'd0);
        // data holds while nothing is accepted
        check("opcode", 64'(opcode), 64'd0);
        check("next_pc", 64'(next_pc), 64'd0);
        valid_in = 1'b0;

        // every opcode, followed by two random unsigned fields
        repeat (2) begin
            for (int op = 0; op < 256; op++) begin
                n1 = rand_len(5);
                n2 = rand_len(5);
                w  = put_leb(noise_window(8'(op)), 1, rand_uval(n1), n1);
                issue(put_leb(w, 1 + n1, rand_uval(n2), n2), 1'b0);
            end
        end

        repeat (16) begin
            n1 = rand_len(5);
            w  = noise_window(wasm_pkg::OPC_I32_CONST);
            issue(put_leb(w, 1, rand_sval((7 * n1 < 32) ? 7 * n1 : 32), n1), 1'b0);
            n1 = rand_len(10);
            w  = noise_window(wasm_pkg::OPC_I64_CONST);
            issue(put_leb(w, 1, rand_sval((7 * n1 < 64) ? 7 * n1 : 64), n1), 1'b0);
        end
        w = noise_window(wasm_pkg::OPC_I32_CONST);
        issue(put_leb(w, 1, 64'hFFFF_FFFF_FFFF_FFFF, 5), 1'b0);
        w = noise_window(wasm_pkg::OPC_I64_CONST);
        issue(put_leb(w, 1, 64'hFFFF_FFFF_FFFF_FFFE, 10), 1'b0);

        repeat (4) begin
            issue(noise_window(wasm_pkg::OPC_F32_CONST), 1'b0);
            issue(noise_window(wasm_pkg::OPC_F64_CONST), 1'b0);
            issue(noise_window(wasm_pkg::OPC_MEMORY_SIZE), 1'b0);
            issue(noise_window(wasm_pkg::OPC_MEMORY_GROW), 1'b0);
        end

        // block, loop and if with each kind of block type
        for (int k = 0; k < 3; k++) begin
            w = noise_window(wasm_pkg::OPC_BLOCK + 8'(k));
            w[15:8] = wasm_pkg::BT_EMPTY;
            issue(w, 1'b0);
            w[15:8] = wasm_pkg::BT_VALTYPE_LO + 8'(rand_len(4) - 1);
            issue(w, 1'b0);
            w[15:8] = wasm_pkg::BT_FUNCREF;
            issue(w, 1'b0);
            w[15:8] = wasm_pkg::BT_EXTERNREF;
            issue(w, 1'b0);
            issue(put_leb(w, 1, 64'd5, 1), 1'b0);
            n1 = 1 + rand_len(2);
            issue(put_leb(w, 1, rand_uval(n1) | 64'h80, n1), 1'b0);
        end

        repeat (16) issue(noise_window(8'($random(seed))), 1'b1);
        @(negedge clk);
        valid_in = 1'b0;

        wait_cnt = 0;
        while (win_q.size() != 0 && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt = wait_cnt + 1;
        end
        if (win_q.size() != 0) begin
            abort_run("timed out draining the pending instructions");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+tests
rtl/wasm_pkg.sv
rtl/wasm_leb_decoder.sv
rtl/wasm_opcode_classifier.sv
rtl/wasm_immediate_unit.sv
rtl/wasm_decoder.sv
tests/tb_wasm_decoder.sv

/* Makefile */
# Verilator build and run of the wasm decoder testbench

BIN  := obj_dir/Vtb_wasm_decoder
SRCS := $(wildcard rtl/*.sv tests/*.sv tests/*.svh) compile.f

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "test passed" sim.log

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	verilator --binary --timing -f compile.f --top-module tb_wasm_decoder

clean:
	rm -rf obj_dir sim.log
